// ==== common/riscv_isa_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~
// rv32i subset isa definitions
// instruction formats, opcodes and funct3 codes
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package riscv_isa_pkg;

	localparam int xlen = 32;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one word, five ways to read it
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		j_fmt_t j;
	} instr_t;

	localparam logic [6:0] op_rtype  = 7'b0110011;
	localparam logic [6:0] op_itype  = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	localparam logic [2:0] f3_add  = 3'b000; // also sub
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_srl  = 3'b101; // also sra
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	localparam logic [31:0] nop_instr = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire

// ==== common/core_ctrl_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~
// core control definitions
// control word, alu codes and store port bus
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package core_ctrl_pkg;

	// {funct7[5], funct3}
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111,
		alu_sub  = 4'b1000,
		alu_sra  = 4'b1101
	} alu_op_e;

	typedef enum logic [1:0] {
		class_add = 2'b00, // lw, sw, jal
		class_sub = 2'b01, // beq compare
		class_reg = 2'b10,
		class_imm = 2'b11
	} alu_class_e;

	typedef enum logic [1:0] {
		res_alu = 2'b00,
		res_mem = 2'b01,
		res_pc4 = 2'b10
	} result_sel_e;

	typedef struct packed {
		logic        reg_write;
		logic        alu_src_imm;
		logic        mem_write;
		logic        branch;
		logic        jump;
		result_sel_e result_sel;
	} ctrl_t;

	typedef struct packed {
		logic                          valid;
		logic [riscv_isa_pkg::xlen-1:0] addr;
		logic [riscv_isa_pkg::xlen-1:0] data;
	} store_bus_t;

	localparam int dmem_words = 64;

endpackage

`default_nettype wire

// ==== hw/controller/main_decoder.sv ====
//~~~~~~~~~~~~~~~~~~~~
// main decoder
// opcode to control word and alu class
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module main_decoder (
	input  logic [6:0]                opcode,
	input  logic [2:0]                funct3,
	output core_ctrl_pkg::ctrl_t      ctrl,
	output core_ctrl_pkg::alu_class_e alu_class
);

	import riscv_isa_pkg::*;
	import core_ctrl_pkg::*;

	logic imm_shift;

	assign imm_shift = (funct3 == f3_sll) || (funct3 == f3_srl);

	always_comb begin
		// no-op word unless the opcode says otherwise
		ctrl       = '0;
		ctrl.result_sel = res_alu;
		alu_class  = class_add;
		case (opcode)
			op_rtype: begin
				ctrl.reg_write = 1'b1;
				alu_class      = class_reg;
			end
			op_itype: begin
				if (!imm_shift) begin // slli/srli/srai unsupported
					ctrl.reg_write   = 1'b1;
					ctrl.alu_src_imm = 1'b1;
					alu_class        = class_imm;
				end
			end
			op_load: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.result_sel  = res_mem;
			end
			op_store: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
			end
			op_branch: begin
				ctrl.branch = 1'b1;
				alu_class   = class_sub; // compare by subtracting
			end
			op_jal: begin
				ctrl.reg_write  = 1'b1;
				ctrl.jump       = 1'b1;
				ctrl.result_sel = res_pc4; // link value
			end
			default: ; // illegal op, stays a no-op
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/controller/alu_decoder.sv ====
//~~~~~~~~~~~~~~~~~~~~
// alu decoder
// class, funct3 and funct7[5] to alu op
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module alu_decoder (
	input  core_ctrl_pkg::alu_class_e alu_class,
	input  logic [2:0]                funct3,
	input  logic                      funct7_5,
	output core_ctrl_pkg::alu_op_e    alu_op
);

	import riscv_isa_pkg::*;
	import core_ctrl_pkg::*;

	logic alt; // sub / sra, register form only

	assign alt = (alu_class == class_reg) && funct7_5;

	always_comb begin
		alu_op = alu_add;
		case (alu_class)
			class_add: alu_op = alu_add;
			class_sub: alu_op = alu_sub;
			class_reg, class_imm: begin
				case (funct3)
					f3_add:  alu_op = alt ? alu_sub : alu_add;
					f3_sll:  alu_op = alu_sll;
					f3_slt:  alu_op = alu_slt;
					f3_sltu: alu_op = alu_sltu;
					f3_xor:  alu_op = alu_xor;
					f3_srl:  alu_op = alt ? alu_sra : alu_srl;
					f3_or:   alu_op = alu_or;
					f3_and:  alu_op = alu_and;
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/controller/controller.sv ====
//~~~~~~~~~~~~~~~~~~~~
// instruction controller
// main and alu decoders plus pc select
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module controller (
	input  riscv_isa_pkg::instr_t   instr,
	input  logic                    zero,
	output core_ctrl_pkg::ctrl_t    ctrl,
	output core_ctrl_pkg::alu_op_e  alu_op,
	output logic                    pc_src
);

	import core_ctrl_pkg::*;

	alu_class_e alu_class;

	main_decoder md0 (
		.opcode    (instr.r.opcode),
		.funct3    (instr.r.funct3),
		.ctrl      (ctrl),
		.alu_class (alu_class)
	);

	alu_decoder ad0 (
		.alu_class (alu_class),
		.funct3    (instr.r.funct3),
		.funct7_5  (instr.r.funct7[5]),
		.alu_op    (alu_op)
	);

	// taken beq or any jal
	assign pc_src = (ctrl.branch & zero) | ctrl.jump;

	// a store never also writes back a register
	always_comb begin
		assert (!(ctrl.mem_write && ctrl.reg_write))
			else $error("controller: mem_write and reg_write both set");
	end

endmodule

`default_nettype wire

// ==== hw/datapath/alu.sv ====
//~~~~~~~~~~~~~~~~~~~~
// 32-bit alu
// add, sub, logic, shifts, compares, zero flag
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic [riscv_isa_pkg::xlen-1:0] a,
	input  logic [riscv_isa_pkg::xlen-1:0] b,
	input  core_ctrl_pkg::alu_op_e         op,
	output logic [riscv_isa_pkg::xlen-1:0] y,
	output logic                           zero
);

	import riscv_isa_pkg::*;
	import core_ctrl_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			alu_add:  y = a + b;
			alu_sub:  y = a - b;
			alu_sll:  y = a << shamt;
			alu_slt:  y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu: y = {{(xlen-1){1'b0}}, a < b};
			alu_xor:  y = a ^ b;
			alu_srl:  y = a >> shamt;
			alu_sra:  y = $unsigned($signed(a) >>> shamt); // keeps sign
			alu_or:   y = a | b;
			alu_and:  y = a & b;
			default:  y = '0;
		endcase
	end

	assign zero = (y == '0);

	always_comb begin
		assert (op inside {alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		                   alu_xor, alu_srl, alu_sra, alu_or, alu_and})
			else $error("alu: undefined op %b", op);
	end

endmodule

`default_nettype wire

// ==== hw/datapath/register_file.sv ====
//~~~~~~~~~~~~~~~~~~~~
// register file, 32 x 32
// two async reads, one clocked write, x0 is zero
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [4:0]                     ra1,
	input  logic [4:0]                     ra2,
	input  logic [4:0]                     wa,
	input  logic                           we,
	input  logic [riscv_isa_pkg::xlen-1:0] wd,
	output logic [riscv_isa_pkg::xlen-1:0] rd1,
	output logic [riscv_isa_pkg::xlen-1:0] rd2
);

	import riscv_isa_pkg::*;

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst)
			regs <= '{default: '0};
		else if (we && (wa != 5'd0)) // x0 stays put
			regs[wa] <= wd;
	end

	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

	// x0 must still read zero after any number of writes
	a_x0_zero: assert property (@(posedge clk) disable iff (rst)
		(ra1 == 5'd0) |-> (rd1 == '0))
		else $error("register_file: x0 read back nonzero");

endmodule

`default_nettype wire

// ==== hw/datapath/datapath.sv ====
//~~~~~~~~~~~~~~~~~~~~
// single-cycle datapath
// pc, immediates, register file, alu and muxes
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input  logic                            clk,
	input  logic                            rst,
	input  riscv_isa_pkg::instr_t           instr,
	input  core_ctrl_pkg::ctrl_t            ctrl,
	input  core_ctrl_pkg::alu_op_e          alu_op,
	input  logic                            pc_src,
	input  logic [riscv_isa_pkg::xlen-1:0]  mem_rdata,
	output logic [riscv_isa_pkg::xlen-1:0]  pc,
	output logic                            zero,
	output logic [riscv_isa_pkg::xlen-1:0]  alu_result,
	output logic [riscv_isa_pkg::xlen-1:0]  rs2_data
);

	import riscv_isa_pkg::*;
	import core_ctrl_pkg::*;

	logic [xlen-1:0] pc_plus4, pc_target, pc_next;
	logic [xlen-1:0] imm_i, imm_s, imm_b, imm_j;
	logic [xlen-1:0] rs1_data, src_b, result;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else
			pc <= pc_next;
	end

	// sign-extended immediates, one per format
	assign imm_i = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};
	assign imm_s = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
	assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
	                instr.b.imm10_5, instr.b.imm4_1, 1'b0};
	assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
	                instr.j.imm11, instr.j.imm10_1, 1'b0};

	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + (ctrl.jump ? imm_j : imm_b);
	assign pc_next   = pc_src ? pc_target : pc_plus4;

	register_file rf0 (
		.clk (clk),
		.rst (rst),
		.ra1 (instr.r.rs1),
		.ra2 (instr.r.rs2),
		.wa  (instr.r.rd),
		.we  (ctrl.reg_write),
		.wd  (result),
		.rd1 (rs1_data),
		.rd2 (rs2_data)
	);

	// stores take the s-immediate, everything else the i-immediate
	assign src_b = !ctrl.alu_src_imm ? rs2_data :
	               ctrl.mem_write    ? imm_s    : imm_i;

	alu alu0 (
		.a    (rs1_data),
		.b    (src_b),
		.op   (alu_op),
		.y    (alu_result),
		.zero (zero)
	);

	always_comb begin
		case (ctrl.result_sel)
			res_mem: result = mem_rdata;
			res_pc4: result = pc_plus4;
			default: result = alu_result;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/data_memory.sv ====
//~~~~~~~~~~~~~~~~~~~~
// data memory, 64 words
// async read, clocked word write
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module data_memory (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           we,
	input  logic [riscv_isa_pkg::xlen-1:0] addr,
	input  logic [riscv_isa_pkg::xlen-1:0] wdata,
	output logic [riscv_isa_pkg::xlen-1:0] rdata
);

	import riscv_isa_pkg::*;
	import core_ctrl_pkg::*;

	logic [xlen-1:0] mem [dmem_words];
	logic [$clog2(dmem_words)-1:0] idx; // word index, wraps

	assign idx = addr[$clog2(dmem_words)+1:2];

	always_ff @(posedge clk) begin
		if (rst)
			mem <= '{default: '0};
		else if (we)
			mem[idx] <= wdata;
	end

	assign rdata = mem[idx];

	a_word_aligned: assert property (@(posedge clk) disable iff (rst)
		we |-> (addr[1:0] == 2'b00))
		else $error("data_memory: misaligned store to %h", addr);

endmodule

`default_nettype wire

// ==== hw/riscv_core.sv ====
//~~~~~~~~~~~~~~~~~~~~
// rv32i subset core, single cycle
// controller, datapath and data memory
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
	input  logic                           clk,
	input  logic                           rst,
	input  riscv_isa_pkg::instr_t          instr,
	output logic [riscv_isa_pkg::xlen-1:0] pc,
	output core_ctrl_pkg::store_bus_t      store
);

	import riscv_isa_pkg::*;
	import core_ctrl_pkg::*;

	ctrl_t           ctrl;
	alu_op_e         alu_op;
	logic            pc_src, zero;
	logic [xlen-1:0] alu_result, rs2_data, mem_rdata;

	controller ctrl0 (
		.instr  (instr),
		.zero   (zero),
		.ctrl   (ctrl),
		.alu_op (alu_op),
		.pc_src (pc_src)
	);

	datapath dp0 (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.ctrl       (ctrl),
		.alu_op     (alu_op),
		.pc_src     (pc_src),
		.mem_rdata  (mem_rdata),
		.pc         (pc),
		.zero       (zero),
		.alu_result (alu_result),
		.rs2_data   (rs2_data)
	);

	data_memory dmem0 (
		.clk   (clk),
		.rst   (rst),
		.we    (ctrl.mem_write),
		.addr  (alu_result),
		.wdata (rs2_data),
		.rdata (mem_rdata)
	);

	// store strobe mirrors the memory write, never in reset
	assign store.valid = ctrl.mem_write & ~rst;
	assign store.addr  = alu_result;
	assign store.data  = rs2_data;

endmodule

`default_nettype wire

// ==== testbench/tb_riscv_core.sv ====
//~~~~~~~~~~~~~~~~~~~~
// riscv_core testbench
// feeds instructions per cycle, checks pc and store port from the cases file
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core;

	import riscv_isa_pkg::*;
	import core_ctrl_pkg::*;

	localparam string case_file = "testbench/riscv_core_cases.txt";

	logic            clk = 1'b0;
	logic            rst;
	instr_t          instr;
	logic [xlen-1:0] pc;
	store_bus_t      store;

	// one entry per instruction cycle
	logic [31:0] case_instr [$];
	logic [31:0] case_pc    [$];
	logic        case_valid [$];
	logic [31:0] case_addr  [$];
	logic [31:0] case_data  [$];

	logic file_ok     = 1'b0;
	logic run_started = 1'b0;
	int   cur_case    = 0;
	int   check_count = 0;
	int   error_count = 0;
	int   cycle_count = 0;
	int   cycle_limit = 0;

	riscv_core dut0 (
		.clk   (clk),
		.rst   (rst),
		.instr (instr),
		.pc    (pc),
		.store (store)
	);

	always #50 clk = ~clk; // 100 ns period

	// comment and blank lines give fewer than five fields and are skipped
	task automatic read_cases();
		int          fd;
		int          got;
		int          fields;
		string       line;
		logic [31:0] w_instr, w_pc, w_valid, w_addr, w_data;
		fd = $fopen(case_file, "r");
		if (fd == 0) begin
			file_ok = 1'b0;
		end else begin
			file_ok = 1'b1;
			while (!$feof(fd)) begin
				got = $fgets(line, fd);
				if (got != 0) begin
					fields = $sscanf(line, "%h %h %h %h %h",
						w_instr, w_pc, w_valid, w_addr, w_data);
					if (fields == 5) begin
						case_instr.push_back(w_instr);
						case_pc.push_back(w_pc);
						case_valid.push_back(w_valid[0]);
						case_addr.push_back(w_addr);
						case_data.push_back(w_data);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic report_mismatch(input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		error_count = error_count + 1;
		$display("MISMATCH at %0t: case %0d %s expected %h got %h",
			$time, cur_case, field, expected, actual);
	endtask

	// guard against a run that never reaches its end
	always @(posedge clk) begin
		if (run_started) begin
			cycle_count = cycle_count + 1;
			if (cycle_count > cycle_limit) begin
				$display("timeout: test did not end within %0d cycles", cycle_limit);
				$display("Something failed");
				$finish;
			end
		end
	end

	initial begin
		rst   = 1'b1;
		instr = nop_instr;
		read_cases();
		if (!file_ok || case_instr.size() == 0) begin
			$display("could not read any test case from %s", case_file);
			$display("Something failed");
			$finish;
		end else begin
			cycle_limit = case_instr.size() + 20;
			repeat (4) @(posedge clk);
			#1;
			rst         = 1'b0;
			run_started = 1'b1;
			for (cur_case = 0; cur_case < case_instr.size(); cur_case++) begin
				instr = case_instr[cur_case]; // 1 ns after the edge
				@(negedge clk);
				check_count = check_count + 2;
				if (pc !== case_pc[cur_case])
					report_mismatch("pc", case_pc[cur_case], pc);
				if (store.valid !== case_valid[cur_case])
					report_mismatch("store.valid", {31'd0, case_valid[cur_case]},
						{31'd0, store.valid});
				// addr and data only mean something during the strobe
				if (case_valid[cur_case]) begin
					check_count = check_count + 2;
					if (store.addr !== case_addr[cur_case])
						report_mismatch("store.addr", case_addr[cur_case], store.addr);
					if (store.data !== case_data[cur_case])
						report_mismatch("store.data", case_data[cur_case], store.data);
				end
				@(posedge clk);
				#1;
			end
			instr = nop_instr;
			$display("%0d cases, %0d checks, %0d errors",
				case_instr.size(), check_count, error_count);
			if (error_count == 0)
				$display("Everything OK");
			else
				$display("Something failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/riscv_core_cases.txt ====
// columns: instr  expected_pc  store_valid  store_addr  store_data  (hex)
// x1=5, x2=-1792, x3=0x40 base, x4=12; store addr/data ignored when valid is 0
00500093 00000000 0 00000000 00000000
90000113 00000004 0 00000000 00000000
04000193 00000008 0 00000000 00000000
00C00213 0000000C 0 00000000 00000000
002082B3 00000010 0 00000000 00000000
0051A023 00000014 1 00000040 FFFFF905
402082B3 00000018 0 00000000 00000000
0051A223 0000001C 1 00000044 00000705
001112B3 00000020 0 00000000 00000000
0051A423 00000024 1 00000048 FFFF2000
001122B3 00000028 0 00000000 00000000
0051A623 0000002C 1 0000004C 00000001
001132B3 00000030 0 00000000 00000000
0051A823 00000034 1 00000050 00000000
004142B3 00000038 0 00000000 00000000
0051AA23 0000003C 1 00000054 FFFFF90C
001152B3 00000040 0 00000000 00000000
0051AC23 00000044 1 00000058 07FFFFC8
401152B3 00000048 0 00000000 00000000
0051AE23 0000004C 1 0000005C FFFFFFC8
0040E2B3 00000050 0 00000000 00000000
0251A023 00000054 1 00000060 0000000D
0040F2B3 00000058 0 00000000 00000000
0251A223 0000005C 1 00000064 00000004
0081A303 00000060 0 00000000 00000000
0261A423 00000064 1 00000068 FFFF2000
00208863 00000068 0 00000000 00000000
00108663 0000006C 0 00000000 00000000
010003EF 00000078 0 00000000 00000000
0271A623 00000088 1 0000006C 0000007C
FF5FF46F 0000008C 0 00000000 00000000
0281A823 00000080 1 00000070 00000090
00C0006F 00000084 0 00000000 00000000
FFFFFFFF 00000090 0 00000000 00000000
00309293 00000094 0 00000000 00000000
0251AA23 00000098 1 00000074 00000004
04D00013 0000009C 0 00000000 00000000
0201AC23 000000A0 1 00000078 00000000
00000013 000000A4 0 00000000 00000000

// ==== vlog.f ====
common/riscv_isa_pkg.sv
common/core_ctrl_pkg.sv
hw/controller/main_decoder.sv
hw/controller/alu_decoder.sv
hw/controller/controller.sv
hw/datapath/alu.sv
hw/datapath/register_file.sv
hw/datapath/datapath.sv
hw/data_memory.sv
hw/riscv_core.sv
testbench/tb_riscv_core.sv

// ==== Makefile ====
# Verilator build for the riscv_core testbench

VERILATOR ?= verilator
TOP       ?= tb_riscv_core
RTL_TOP   ?= riscv_core
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
